/* hw/mv_pkg.sv */
`default_nettype none

package mv_pkg;

  // one vector component, half-pel units
  typedef logic signed [15:0] mv_t;

  // motion_code spans -16..16, so +16 needs the sixth bit
  typedef logic signed [5:0] mcode_t;

  typedef logic [31:0] window_t;  // oldest bit at msb
  typedef logic [15:0] peek_t;    // next stream bits
  typedef logic [4:0]  shamt_t;   // flush length 0..16

  // largest legal r_size, sizes the residual ports
  localparam int max_r_size = 8;

endpackage

`default_nettype wire

/* hw/bit_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module bit_reader (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  byte_valid,
  output logic                 byte_ready,
  input  wire  [7:0]           byte_data,
  input  wire                  flush_valid,
  input  wire  mv_pkg::shamt_t flush_len,
  output mv_pkg::peek_t        peek,
  output logic [5:0]           avail
);

  mv_pkg::window_t win;
  mv_pkg::window_t win_nxt;
  mv_pkg::shamt_t  shift;
  logic [5:0]      cnt;
  logic [5:0]      cnt_left;
  logic [5:0]      cnt_nxt;
  logic            load;

  assign load     = byte_valid && byte_ready;
  assign shift    = flush_valid ? flush_len : '0;
  assign cnt_left = cnt - {1'b0, shift};

  // flush first, then the new byte lands just below what is left
  always_comb begin
    win_nxt = win << shift;
    cnt_nxt = cnt_left;
    if (load) begin
      win_nxt = win_nxt | ({byte_data, 24'h000000} >> cnt_left);
      cnt_nxt = cnt_left + 6'd8;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      win        <= '0;  // bits below cnt must stay zero
      cnt        <= '0;
      byte_ready <= 1'b0;
    end else begin
      win        <= win_nxt;
      cnt        <= cnt_nxt;
      byte_ready <= (cnt_nxt <= 6'd24);  // room for a whole byte
    end
  end

  assign peek  = win[31:16];
  assign avail = cnt;

  // the parser must never consume bits it has not seen
  a_flush_in_range: assert property (
    @(posedge clk) disable iff (rst)
    flush_valid |-> ({1'b0, flush_len} <= avail)
  );

endmodule

`default_nettype wire

/* hw/motion_code_vlc.sv */
`timescale 1ns/1ps
`default_nettype none

module motion_code_vlc (
  input  wire  [10:0]          bits,
  output mv_pkg::mcode_t       code,
  output mv_pkg::shamt_t       code_len
);

  logic [4:0] mag;
  logic       neg;

  // table B-10, leading zeros pick the group, sign bit comes last
  always_comb begin
    casez (bits)
      11'b1??????????: begin mag = 5'd0;  code_len = 5'd1;  end
      11'b01?????????: begin mag = 5'd1;  code_len = 5'd3;  end
      11'b001????????: begin mag = 5'd2;  code_len = 5'd4;  end
      11'b0001???????: begin mag = 5'd3;  code_len = 5'd5;  end
      11'b000011?????: begin mag = 5'd4;  code_len = 5'd7;  end
      11'b0000101????: begin mag = 5'd5;  code_len = 5'd8;  end
      11'b0000100????: begin mag = 5'd6;  code_len = 5'd8;  end
      11'b0000011????: begin mag = 5'd7;  code_len = 5'd8;  end
      11'b000001011??: begin mag = 5'd8;  code_len = 5'd10; end
      11'b000001010??: begin mag = 5'd9;  code_len = 5'd10; end
      11'b000001001??: begin mag = 5'd10; code_len = 5'd10; end
      11'b0000010001?: begin mag = 5'd11; code_len = 5'd11; end
      11'b0000010000?: begin mag = 5'd12; code_len = 5'd11; end
      11'b0000001111?: begin mag = 5'd13; code_len = 5'd11; end
      11'b0000001110?: begin mag = 5'd14; code_len = 5'd11; end
      11'b0000001101?: begin mag = 5'd15; code_len = 5'd11; end
      11'b0000001100?: begin mag = 5'd16; code_len = 5'd11; end
      default: begin
        // illegal prefix, step over one bit
        mag      = 5'd0;
        code_len = 5'd1;
      end
    endcase
  end

  // sign sits in the last bit of the code word
  assign neg  = bits[4'd11 - code_len[3:0]];
  assign code = neg ? -mv_pkg::mcode_t'({1'b0, mag}) : mv_pkg::mcode_t'({1'b0, mag});

endmodule

`default_nettype wire

/* hw/mv_field_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module mv_field_parser #(
  parameter int h_r_size = 1,
  parameter int v_r_size = 1
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              cmd_valid,
  output logic                             cmd_ready,
  input  wire  mv_pkg::mv_t                cmd_pred_h,
  input  wire  mv_pkg::mv_t                cmd_pred_v,
  input  wire                              cmd_mvscale,
  input  wire  mv_pkg::peek_t              peek,
  input  wire  [5:0]                       avail,
  output logic                             flush_valid,
  output mv_pkg::shamt_t                   flush_len,
  output logic [10:0]                      vlc_bits,
  input  wire  mv_pkg::mcode_t             vlc_code,
  input  wire  mv_pkg::shamt_t             vlc_len,
  output logic                             h_job_valid,
  input  wire                              h_job_ready,
  output mv_pkg::mv_t                      h_pred,
  output mv_pkg::mcode_t                   h_code,
  output logic [mv_pkg::max_r_size-1:0]    h_residual,
  output logic                             v_job_valid,
  input  wire                              v_job_ready,
  output mv_pkg::mv_t                      v_pred,
  output mv_pkg::mcode_t                   v_code,
  output logic [mv_pkg::max_r_size-1:0]    v_residual,
  output logic                             meta_valid,
  input  wire                              meta_ready,
  output logic                             field_sel,
  output logic                             mvscale
);

  typedef enum logic [2:0] {
    st_idle, st_field, st_h_code, st_h_res, st_v_code, st_v_res, st_issue
  } state_t;

  localparam mv_pkg::shamt_t h_len = mv_pkg::shamt_t'(h_r_size);
  localparam mv_pkg::shamt_t v_len = mv_pkg::shamt_t'(v_r_size);

  state_t      state;
  logic [15:0] h_bits;
  logic [15:0] v_bits;
  logic        need_res;
  logic        h_load;
  logic        v_load;
  logic        drained;

  assign cmd_ready = (state == st_idle);
  assign vlc_bits  = peek[15:5];
  assign h_bits    = peek >> (16 - h_r_size);  // residual right aligned
  assign v_bits    = peek >> (16 - v_r_size);

  // each step waits until its bits are in the window
  always_comb begin
    flush_valid = 1'b0;
    flush_len   = vlc_len;
    need_res    = 1'b0;
    case (state)
      st_field: begin
        flush_valid = (avail != 6'd0);
        flush_len   = 5'd1;
      end
      st_h_code: begin
        flush_valid = (avail >= 6'd11);
        need_res    = (h_r_size != 0) && (vlc_code != 0);
      end
      st_h_res: begin
        flush_valid = (avail >= h_r_size);
        flush_len   = h_len;
      end
      st_v_code: begin
        flush_valid = (avail >= 6'd11);
        need_res    = (v_r_size != 0) && (vlc_code != 0);
      end
      st_v_res: begin
        flush_valid = (avail >= v_r_size);
        flush_len   = v_len;
      end
      default: ;
    endcase
  end

  assign h_load  = flush_valid && (state == st_h_res || (state == st_h_code && !need_res));
  assign v_load  = flush_valid && (state == st_v_res || (state == st_v_code && !need_res));
  assign drained = (!h_job_valid || h_job_ready) && (!v_job_valid || v_job_ready) &&
                   (!meta_valid || meta_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= st_idle;
      h_job_valid <= 1'b0;
      v_job_valid <= 1'b0;
      meta_valid  <= 1'b0;
    end else begin
      if (h_job_ready) h_job_valid <= 1'b0;
      if (v_job_ready) v_job_valid <= 1'b0;
      if (meta_ready) meta_valid <= 1'b0;
      if (h_load) h_job_valid <= 1'b1;  // h decodes while v is parsed
      if (v_load) begin
        v_job_valid <= 1'b1;
        meta_valid  <= 1'b1;
      end
      case (state)
        st_idle:   if (cmd_valid) state <= st_field;
        st_field:  if (flush_valid) state <= st_h_code;
        st_h_code: if (flush_valid) state <= need_res ? st_h_res : st_v_code;
        st_h_res:  if (flush_valid) state <= st_v_code;
        st_v_code: if (flush_valid) state <= need_res ? st_v_res : st_issue;
        st_v_res:  if (flush_valid) state <= st_issue;
        st_issue:  if (drained) state <= st_idle;
        default:   state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_idle && cmd_valid) begin
      h_pred  <= cmd_pred_h;
      v_pred  <= cmd_mvscale ? (cmd_pred_v >>> 1) : cmd_pred_v;  // frame to field
      mvscale <= cmd_mvscale;
    end
    if (state == st_field && flush_valid) field_sel <= peek[15];
    if (state == st_h_code && flush_valid) begin
      h_code     <= vlc_code;
      h_residual <= '0;
    end
    if (state == st_h_res && flush_valid) h_residual <= h_bits[mv_pkg::max_r_size-1:0];
    if (state == st_v_code && flush_valid) begin
      v_code     <= vlc_code;
      v_residual <= '0;
    end
    if (state == st_v_res && flush_valid) v_residual <= v_bits[mv_pkg::max_r_size-1:0];
  end

  a_h_slot_free: assert property (@(posedge clk) disable iff (rst) h_load |-> !h_job_valid);
  a_v_slot_free: assert property (@(posedge clk) disable iff (rst) v_load |-> !v_job_valid);

endmodule

`default_nettype wire

/* hw/mv_component_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mv_component_decoder #(
  parameter int r_size = 1
) (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              job_valid,
  output logic                             job_ready,
  input  wire  mv_pkg::mv_t                pred,
  input  wire  mv_pkg::mcode_t             code,
  input  wire  [mv_pkg::max_r_size-1:0]    residual,
  output logic                             out_valid,
  input  wire                              out_ready,
  output mv_pkg::mv_t                      mv
);

  localparam int w = r_size + 5;  // range is 32*f wide

  logic [15:0] mag;
  logic [15:0] delta_mag;
  mv_pkg::mv_t delta;
  mv_pkg::mv_t sum;
  mv_pkg::mv_t wrapped;

  always_comb begin
    mag       = 16'((code < 0) ? -code : code);
    delta_mag = ((mag - 16'd1) << r_size) + 16'(residual) + 16'd1;
    if (r_size == 0 || code == 0) begin
      delta = mv_pkg::mv_t'(code);
    end else begin
      delta = (code < 0) ? -mv_pkg::mv_t'(delta_mag) : mv_pkg::mv_t'(delta_mag);
    end
    sum     = pred + delta;
    // low w bits as signed is the modulo into -16f..16f-1
    wrapped = mv_pkg::mv_t'(signed'(sum[w-1:0]));
  end

  assign job_ready = !out_valid || out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (job_valid && job_ready) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (job_valid && job_ready) mv <= wrapped;
  end

endmodule

`default_nettype wire

/* hw/mv_assembler.sv */
`timescale 1ns/1ps
`default_nettype none

module mv_assembler (
  input  wire               clk,
  input  wire               rst,
  input  wire               h_valid,
  output logic              h_ready,
  input  wire  mv_pkg::mv_t h_mv,
  input  wire               v_valid,
  output logic              v_ready,
  input  wire  mv_pkg::mv_t v_mv,
  input  wire               meta_valid,
  output logic              meta_ready,
  input  wire               field_sel,
  input  wire               mvscale,
  output logic              res_valid,
  input  wire               res_ready,
  output mv_pkg::mv_t       res_mv_h,
  output mv_pkg::mv_t       res_mv_v,
  output logic              res_field_sel
);

  logic join_go;

  // all three parts together, and room in the output register
  assign join_go    = h_valid && v_valid && meta_valid && (!res_valid || res_ready);
  assign h_ready    = join_go;
  assign v_ready    = join_go;
  assign meta_ready = join_go;

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (join_go) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (join_go) begin
      res_mv_h      <= h_mv;
      res_mv_v      <= mvscale ? mv_pkg::mv_t'(v_mv <<< 1) : v_mv;  // back to frame units
      res_field_sel <= field_sel;
    end
  end

  a_res_hold: assert property (
    @(posedge clk) disable iff (rst)
    res_valid && !res_ready |=> res_valid && $stable(res_mv_h) && $stable(res_mv_v) &&
                                $stable(res_field_sel)
  );

endmodule

`default_nettype wire

/* hw/mv_decode_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mv_decode_top #(
  parameter int h_r_size = 2,
  parameter int v_r_size = 1
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               byte_valid,
  output logic              byte_ready,
  input  wire  [7:0]        byte_data,
  input  wire               cmd_valid,
  output logic              cmd_ready,
  input  wire  mv_pkg::mv_t cmd_pred_h,
  input  wire  mv_pkg::mv_t cmd_pred_v,
  input  wire               cmd_mvscale,
  output logic              res_valid,
  input  wire               res_ready,
  output mv_pkg::mv_t       res_mv_h,
  output mv_pkg::mv_t       res_mv_v,
  output logic              res_field_sel
);

  mv_pkg::peek_t                   peek;
  logic [5:0]                      avail;
  logic                            flush_valid;
  mv_pkg::shamt_t                  flush_len;
  logic [10:0]                     vlc_bits;
  mv_pkg::mcode_t                  vlc_code;
  mv_pkg::shamt_t                  vlc_len;
  logic                            h_job_valid, h_job_ready;
  logic                            v_job_valid, v_job_ready;
  mv_pkg::mv_t                     h_pred, v_pred;
  mv_pkg::mcode_t                  h_code, v_code;
  logic [mv_pkg::max_r_size-1:0]   h_residual, v_residual;
  logic                            h_out_valid, h_out_ready;
  logic                            v_out_valid, v_out_ready;
  mv_pkg::mv_t                     h_mv, v_mv;
  logic                            meta_valid, meta_ready;
  logic                            field_sel, mvscale;

  bit_reader i_reader (
    .clk, .rst, .byte_valid, .byte_ready, .byte_data,
    .flush_valid, .flush_len, .peek, .avail
  );

  motion_code_vlc i_vlc (.bits(vlc_bits), .code(vlc_code), .code_len(vlc_len));

  mv_field_parser #(.h_r_size(h_r_size), .v_r_size(v_r_size)) i_parser (
    .clk, .rst, .cmd_valid, .cmd_ready, .cmd_pred_h, .cmd_pred_v, .cmd_mvscale,
    .peek, .avail, .flush_valid, .flush_len, .vlc_bits, .vlc_code, .vlc_len,
    .h_job_valid, .h_job_ready, .h_pred, .h_code, .h_residual,
    .v_job_valid, .v_job_ready, .v_pred, .v_code, .v_residual,
    .meta_valid, .meta_ready, .field_sel, .mvscale
  );

  mv_component_decoder #(.r_size(h_r_size)) i_h_dec (
    .clk, .rst, .job_valid(h_job_valid), .job_ready(h_job_ready), .pred(h_pred),
    .code(h_code), .residual(h_residual), .out_valid(h_out_valid),
    .out_ready(h_out_ready), .mv(h_mv)
  );

  mv_component_decoder #(.r_size(v_r_size)) i_v_dec (
    .clk, .rst, .job_valid(v_job_valid), .job_ready(v_job_ready), .pred(v_pred),
    .code(v_code), .residual(v_residual), .out_valid(v_out_valid),
    .out_ready(v_out_ready), .mv(v_mv)
  );

  mv_assembler i_asm (
    .clk, .rst,
    .h_valid(h_out_valid), .h_ready(h_out_ready), .h_mv,
    .v_valid(v_out_valid), .v_ready(v_out_ready), .v_mv,
    .meta_valid, .meta_ready, .field_sel, .mvscale,
    .res_valid, .res_ready, .res_mv_h, .res_mv_v, .res_field_sel
  );

endmodule

`default_nettype wire

/* tests/mv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module mv_checker #(
  parameter int h_r_size = 1,
  parameter int v_r_size = 1
) (
  input  wire               clk,
  input  wire               rst,
  input  wire               cmd_valid,
  input  wire               cmd_ready,
  input  wire  mv_pkg::mv_t cmd_pred_h,
  input  wire  mv_pkg::mv_t cmd_pred_v,
  input  wire               cmd_mvscale,
  input  wire               res_valid,
  input  wire               res_ready,
  input  wire  mv_pkg::mv_t res_mv_h,
  input  wire  mv_pkg::mv_t res_mv_v,
  input  wire               res_field_sel,
  output int                result_count
);

  // stimulus records, one per command, in stream order
  int fsel_q[$];
  int hcode_q[$];
  int hres_q[$];
  int vcode_q[$];
  int vres_q[$];

  // expected results, filled when a command is accepted
  int exp_h_q[$];
  int exp_v_q[$];
  int exp_f_q[$];

  int mismatches = 0;
  int other_errors = 0;
  int results = 0;

  assign result_count = results;

  // delta from code and residual, then wrap into -16f..16f-1
  function automatic int decode_component(input int pred, input int code, input int residual,
                                          input int r_size);
    int f;
    int delta;
    int span;
    int sum;
    f = 1 << r_size;
    if (f == 1 || code == 0) begin
      delta = code;
    end else begin
      delta = ((code < 0) ? -code : code) - 1;
      delta = delta * f + residual + 1;
      if (code < 0) delta = -delta;
    end
    span = 32 * f;
    sum  = pred + delta;
    while (sum < -16 * f) sum = sum + span;
    while (sum >= 16 * f) sum = sum - span;
    return sum;
  endfunction

  task automatic add_detail(input int fsel, input int hcode, input int hres, input int vcode,
                            input int vres);
    fsel_q.push_back(fsel);
    hcode_q.push_back(hcode);
    hres_q.push_back(hres);
    vcode_q.push_back(vcode);
    vres_q.push_back(vres);
  endtask

  task automatic compare_field(input string name, input int got, input int expected);
    if (got != expected) begin
      mismatches++;
      $display("mismatch at %0t: %s got %0d, expected %0d", $time, name, got, expected);
    end
  endtask

  always @(posedge clk) begin : watch_cmd
    int pv;
    int exp_v;
    if (!rst && cmd_valid && cmd_ready) begin
      if (fsel_q.size() == 0) begin
        other_errors++;
        $display("command accepted at %0t with no stimulus record left", $time);
      end else begin
        pv = int'(cmd_pred_v);
        if (cmd_mvscale) pv = pv >>> 1;  // field units, rounded down
        exp_v = decode_component(pv, vcode_q.pop_front(), vres_q.pop_front(), v_r_size);
        if (cmd_mvscale) exp_v = exp_v * 2;
        exp_h_q.push_back(decode_component(int'(cmd_pred_h), hcode_q.pop_front(),
                                           hres_q.pop_front(), h_r_size));
        exp_v_q.push_back(exp_v);
        exp_f_q.push_back(fsel_q.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    if (!rst && res_valid && res_ready) begin
      if (exp_h_q.size() == 0) begin
        other_errors++;
        $display("result seen at %0t with no command outstanding", $time);
      end else begin
        compare_field("res_mv_h", int'(res_mv_h), exp_h_q.pop_front());
        compare_field("res_mv_v", int'(res_mv_v), exp_v_q.pop_front());
        compare_field("res_field_sel", int'(res_field_sel), exp_f_q.pop_front());
        results++;
      end
    end
  end

  task automatic report_counts(output int total);
    if (exp_h_q.size() != 0) begin
      other_errors = other_errors + exp_h_q.size();
      $display("%0d accepted commands never produced a result", exp_h_q.size());
    end
    $display("checker: %0d results, %0d mismatches, %0d other errors",
             results, mismatches, other_errors);
    total = mismatches + other_errors;
  endtask

endmodule

`default_nettype wire

/* tests/tb_mv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mv_decode;

  localparam int h_r_size = 2;
  localparam int v_r_size = 1;
  localparam int n_cmds   = 64;
  localparam int period   = 100;

  logic        clk;
  logic        rst;
  logic        byte_valid;
  logic        byte_ready;
  logic [7:0]  byte_data;
  logic        cmd_valid;
  logic        cmd_ready;
  mv_pkg::mv_t cmd_pred_h;
  mv_pkg::mv_t cmd_pred_v;
  logic        cmd_mvscale;
  logic        res_valid;
  logic        res_ready;
  mv_pkg::mv_t res_mv_h;
  mv_pkg::mv_t res_mv_v;
  logic        res_field_sel;
  int          result_count;
  int          total_errors;

  integer      seed;
  logic        stress;  // second half adds gaps and back-pressure
  logic        bits_q[$];
  logic [7:0]  byte_q[$];
  int          pred_h_a[n_cmds];
  int          pred_v_a[n_cmds];
  logic        mvscale_a[n_cmds];

  mv_decode_top #(.h_r_size(h_r_size), .v_r_size(v_r_size)) i_dut (
    .clk, .rst, .byte_valid, .byte_ready, .byte_data,
    .cmd_valid, .cmd_ready, .cmd_pred_h, .cmd_pred_v, .cmd_mvscale,
    .res_valid, .res_ready, .res_mv_h, .res_mv_v, .res_field_sel
  );

  mv_checker #(.h_r_size(h_r_size), .v_r_size(v_r_size)) i_chk (
    .clk, .rst, .cmd_valid, .cmd_ready, .cmd_pred_h, .cmd_pred_v, .cmd_mvscale,
    .res_valid, .res_ready, .res_mv_h, .res_mv_v, .res_field_sel, .result_count
  );

  initial clk = 1'b0;
  always #(period / 2) clk = ~clk;

  function automatic int pick_range(input int lo, input int hi);
    int span;
    span = hi - lo + 1;
    return lo + int'({$random(seed)} % span);
  endfunction

  function automatic int pick_code(input int kind);
    int mag;
    if (kind == 0) return pick_range(-1, 1);
    if (kind == 1) begin
      mag = pick_range(8, 16);
      return pick_range(0, 1) ? -mag : mag;
    end
    return pick_range(-16, 16);
  endfunction

  task automatic append_bits(input int value, input int len);
    for (int k = len - 1; k >= 0; k--) bits_q.push_back(value[k]);
  endtask

  // table B-10 prefix without the sign bit
  task automatic append_code(input int code);
    int mag;
    int prefix;
    int plen;
    mag = (code < 0) ? -code : code;
    case (mag)
      0:  begin prefix = 1'b1;          plen = 1;  end
      1:  begin prefix = 2'b01;         plen = 2;  end
      2:  begin prefix = 3'b001;        plen = 3;  end
      3:  begin prefix = 4'b0001;       plen = 4;  end
      4:  begin prefix = 6'b000011;     plen = 6;  end
      5:  begin prefix = 7'b0000101;    plen = 7;  end
      6:  begin prefix = 7'b0000100;    plen = 7;  end
      7:  begin prefix = 7'b0000011;    plen = 7;  end
      8:  begin prefix = 9'b000001011;  plen = 9;  end
      9:  begin prefix = 9'b000001010;  plen = 9;  end
      10: begin prefix = 9'b000001001;  plen = 9;  end
      11: begin prefix = 10'b0000010001; plen = 10; end
      12: begin prefix = 10'b0000010000; plen = 10; end
      13: begin prefix = 10'b0000001111; plen = 10; end
      14: begin prefix = 10'b0000001110; plen = 10; end
      15: begin prefix = 10'b0000001101; plen = 10; end
      default: begin prefix = 10'b0000001100; plen = 10; end
    endcase
    append_bits(prefix, plen);
    if (mag != 0) append_bits((code < 0) ? 1 : 0, 1);  // 1 means negative
  endtask

  task automatic build_stream();
    int kind;
    int mvs;
    int fsel;
    int hc;
    int hr;
    int vc;
    int vr;
    logic [7:0] b;
    for (int i = 0; i < n_cmds; i++) begin
      kind = (i < 8) ? 0 : pick_range(0, 2);
      mvs  = (pick_range(0, 2) == 0);
      fsel = pick_range(0, 1);
      hc   = pick_code(kind);
      vc   = pick_code(kind);
      hr   = (kind == 0) ? 0 : pick_range(0, (1 << h_r_size) - 1);
      vr   = (kind == 0) ? 0 : pick_range(0, (1 << v_r_size) - 1);
      pred_h_a[i]  = pick_range(-64, 63);
      pred_v_a[i]  = mvs ? pick_range(-64, 63) : pick_range(-32, 31);
      mvscale_a[i] = mvs[0];
      append_bits(fsel, 1);
      append_code(hc);
      if (h_r_size != 0 && hc != 0) append_bits(hr, h_r_size);
      append_code(vc);
      if (v_r_size != 0 && vc != 0) append_bits(vr, v_r_size);
      i_chk.add_detail(fsel, hc, hr, vc, vr);
    end
    // ones to the byte boundary, then two bytes so the last code can be peeked
    while (bits_q.size() % 8 != 0) bits_q.push_back(1'b1);
    repeat (16) bits_q.push_back(1'b1);
    while (bits_q.size() > 0) begin
      b = '0;
      for (int k = 0; k < 8; k++) b = {b[6:0], bits_q.pop_front()};
      byte_q.push_back(b);
    end
  endtask

  task automatic drive_commands();
    for (int i = 0; i < n_cmds; i++) begin
      if (i == n_cmds / 2) stress = 1'b1;
      if (stress) repeat (pick_range(0, 3)) @(negedge clk);
      cmd_valid   = 1'b1;
      cmd_pred_h  = mv_pkg::mv_t'(pred_h_a[i]);
      cmd_pred_v  = mv_pkg::mv_t'(pred_v_a[i]);
      cmd_mvscale = mvscale_a[i];
      while (!cmd_ready) @(negedge clk);
      @(negedge clk);  // taken at the edge in between
      cmd_valid = 1'b0;
    end
  endtask

  task automatic drive_bytes();
    while (byte_q.size() > 0) begin
      if (stress && pick_range(0, 3) == 0) begin
        byte_valid = 1'b0;
        repeat (pick_range(1, 4)) @(negedge clk);
      end
      byte_valid = 1'b1;
      byte_data  = byte_q.pop_front();
      while (!byte_ready) @(negedge clk);
      @(negedge clk);
    end
    byte_valid = 1'b0;
  endtask

  task automatic drive_res_ready();
    forever begin
      @(negedge clk);
      res_ready = stress ? (pick_range(0, 2) != 0) : 1'b1;
    end
  endtask

  initial begin
    seed        = 32'hbd24;
    stress      = 1'b0;
    rst         = 1'b1;
    byte_valid  = 1'b0;
    byte_data   = 8'h00;
    cmd_valid   = 1'b0;
    cmd_pred_h  = '0;
    cmd_pred_v  = '0;
    cmd_mvscale = 1'b0;
    res_ready   = 1'b0;
    build_stream();
    repeat (8) @(negedge clk);
    rst = 1'b0;
    fork
      drive_commands();
      drive_bytes();
      drive_res_ready();
    join_none
    wait (result_count == n_cmds);
    repeat (20) @(negedge clk);  // room for a stray extra result
    i_chk.report_counts(total_errors);
    if (total_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // 400 cycles per command plus reset
  initial begin
    #((n_cmds * 400 + 8) * period);
    $display("timeout: %0d of %0d results arrived", result_count, n_cmds);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
hw/mv_pkg.sv
hw/bit_reader.sv
hw/motion_code_vlc.sv
hw/mv_field_parser.sv
hw/mv_component_decoder.sv
hw/mv_assembler.sv
hw/mv_decode_top.sv
tests/mv_checker.sv
tests/tb_mv_decode.sv

/* Bender.yml */
package:
  name: mv_decode

sources:
  - hw/mv_pkg.sv
  - hw/bit_reader.sv
  - hw/motion_code_vlc.sv
  - hw/mv_field_parser.sv
  - hw/mv_component_decoder.sv
  - hw/mv_assembler.sv
  - hw/mv_decode_top.sv
  - target: test
    files:
      - tests/mv_checker.sv
      - tests/tb_mv_decode.sv
